//--- cpu_pkg.sv
package cpu_pkg;

    localparam int data_w = 16;
    localparam int addr_w = 8;
    localparam int reg_n  = 16;

    // instruction fields
    localparam int fld_op_lsb = 12;
    localparam int fld_x_lsb  = 8;
    localparam int fld_y_lsb  = 4;
    localparam int fld_z_lsb  = 0;

    typedef logic [data_w-1:0]        word_t;
    typedef logic [addr_w-1:0]        addr_t;
    typedef logic [$clog2(reg_n)-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        op_sys    = 4'b0000,  // sub-function in bits 1:0
        op_setn   = 4'b0001,
        op_loadn  = 4'b0010,
        op_storen = 4'b0011,
        op_addn   = 4'b0101,
        op_add    = 4'b0110,  // nop and copy via r0
        op_sub    = 4'b0111,  // neg via r0
        op_mul    = 4'b1000,
        op_jumpn  = 4'b1011,
        op_jeqz   = 4'b1100,
        op_jnez   = 4'b1101,
        op_jltz   = 4'b1110,
        op_jgtz   = 4'b1111
    } op_t;

    typedef enum logic [1:0] {
        sys_halt  = 2'b00,
        sys_read  = 2'b01,
        sys_write = 2'b10
    } sys_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch0,
        st_fetch1,
        st_exec0,
        st_exec1,
        st_exec2,
        st_halted
    } step_t;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_mul
    } alu_op_t;

    typedef enum logic [2:0] {
        src_none,
        src_pc,
        src_mem,
        src_reg,
        src_alu,
        src_imm,
        src_in
    } bus_src_t;

endpackage

//--- cpu_regfile.sv
`timescale 1ns/10ps

module cpu_regfile (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t addr,
    input  logic               load,
    input  cpu_pkg::word_t     wdata,
    output cpu_pkg::word_t     rdata
);
    import cpu_pkg::*;

    word_t regs [reg_n];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_n; i++) begin
                regs[i] <= '0;
            end
        end else if (load && addr != '0) begin  // r0 is read-only
            regs[addr] <= wdata;
        end
    end

    assign rdata = (addr == '0) ? '0 : regs[addr];

endmodule

//--- cpu_alu.sv
`timescale 1ns/10ps

module cpu_alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   y
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;  // tmp0 minus tmp1
            alu_mul: y = a * b;  // low half of product
            default: y = '0;
        endcase
    end

endmodule

//--- cpu_memory.sv
`timescale 1ns/10ps

module cpu_memory (
    input  logic           clk,
    input  cpu_pkg::addr_t addr,
    input  cpu_pkg::word_t wdata,
    input  logic           write,
    output cpu_pkg::word_t rdata,
    input  logic           prog_valid,
    input  logic           prog_ready,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data
);
    import cpu_pkg::*;

    word_t mem [2**addr_w];

    always_ff @(posedge clk) begin
        if (prog_valid && prog_ready) begin  // loader only while core is idle
            mem[prog_addr] <= prog_data;
        end else if (write) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

//--- cpu_datapath.sv
`timescale 1ns/10ps

module cpu_datapath (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::bus_src_t  bus_src,
    input  cpu_pkg::reg_addr_t reg_addr,
    input  logic               reg_load,
    input  logic               mar_load,
    input  logic               ir_load,
    input  logic               pc_inc,
    input  logic               pc_load,
    input  logic               tmp0_load,
    input  logic               tmp1_load,
    input  logic               flags_load,
    input  cpu_pkg::alu_op_t   alu_op,
    input  logic               mem_write,
    output cpu_pkg::word_t     ir,
    output logic               zero_flag,
    output logic               sign_flag,
    input  cpu_pkg::word_t     in_data,
    input  cpu_pkg::word_t     mem_rdata,
    output cpu_pkg::addr_t     mem_addr,
    output cpu_pkg::word_t     mem_wdata,
    output cpu_pkg::word_t     out_data
);
    import cpu_pkg::*;

    addr_t pc;
    addr_t mar;
    word_t tmp0;
    word_t tmp1;
    word_t bus;
    word_t imm;
    word_t reg_rdata;
    word_t alu_y;

    assign imm = {{(data_w-addr_w){1'b0}}, ir[addr_w-1:0]};  // zero-extended

    always_comb begin
        case (bus_src)
            src_pc:  bus = {{(data_w-addr_w){1'b0}}, pc};
            src_mem: bus = mem_rdata;
            src_reg: bus = reg_rdata;
            src_alu: bus = alu_y;
            src_imm: bus = imm;
            src_in:  bus = in_data;
            default: bus = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            ir        <= '0;
            zero_flag <= 1'b0;
            sign_flag <= 1'b0;
        end else begin
            if (pc_load) begin
                pc <= bus[addr_w-1:0];
            end else if (pc_inc) begin
                pc <= pc + 1'b1;
            end
            if (ir_load) begin
                ir <= bus;
            end
            if (flags_load) begin
                zero_flag <= (bus == '0);
                sign_flag <= bus[data_w-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mar_load) begin
            mar <= bus[addr_w-1:0];
        end
        if (tmp0_load) begin
            tmp0 <= bus;
        end
        if (tmp1_load) begin
            tmp1 <= bus;
        end
    end

    assign mem_addr  = mar;
    assign mem_wdata = reg_rdata;
    assign out_data  = reg_rdata;

    cpu_regfile regs0 (
        .clk   (clk),
        .rst   (rst),
        .addr  (reg_addr),
        .load  (reg_load),
        .wdata (bus),
        .rdata (reg_rdata)
    );

    cpu_alu alu0 (
        .a  (tmp0),
        .b  (tmp1),
        .op (alu_op),
        .y  (alu_y)
    );

    a_bus_driven: assert property (@(posedge clk) disable iff (rst)
        (reg_load || mar_load || ir_load || pc_load || tmp0_load || tmp1_load ||
         flags_load) |-> bus_src != src_none);

    // storen sets the address one cycle before it writes
    a_write_addr: assert property (@(posedge clk) disable iff (rst)
        mem_write |-> $past(mar_load));

endmodule

//--- cpu_control.sv
`timescale 1ns/10ps

module cpu_control (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  cpu_pkg::word_t     ir,
    input  logic               zero_flag,
    input  logic               sign_flag,
    input  logic               in_valid,
    input  logic               out_ready,
    output logic               in_ready,
    output logic               out_valid,
    output logic               prog_ready,
    output logic               halted,
    output cpu_pkg::bus_src_t  bus_src,
    output cpu_pkg::reg_addr_t reg_addr,
    output logic               reg_load,
    output logic               mar_load,
    output logic               ir_load,
    output logic               pc_inc,
    output logic               pc_load,
    output logic               tmp0_load,
    output logic               tmp1_load,
    output logic               flags_load,
    output logic               mem_write,
    output cpu_pkg::alu_op_t   alu_op
);
    import cpu_pkg::*;

    step_t     step;
    step_t     step_nxt;
    op_t       op;
    sys_t      sys;
    reg_addr_t rx;
    reg_addr_t ry;
    reg_addr_t rz;
    logic      take;

    assign op = op_t'(ir[fld_op_lsb +: $bits(op_t)]);
    assign sys = sys_t'(ir[$bits(sys_t)-1:0]);
    assign rx = ir[fld_x_lsb +: $bits(reg_addr_t)];
    assign ry = ir[fld_y_lsb +: $bits(reg_addr_t)];
    assign rz = ir[fld_z_lsb +: $bits(reg_addr_t)];

    assign prog_ready = (step == st_idle) || (step == st_halted);
    assign halted = (step == st_halted);

    always_comb begin
        case (op)
            op_jeqz: take = zero_flag;
            op_jnez: take = !zero_flag;
            op_jltz: take = sign_flag;
            default: take = !zero_flag && !sign_flag;  // jgtz
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= st_idle;
        end else begin
            step <= step_nxt;
        end
    end

    always_comb begin
        step_nxt   = step;
        bus_src    = src_none;
        reg_addr   = '0;
        reg_load   = 1'b0;
        mar_load   = 1'b0;
        ir_load    = 1'b0;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        tmp0_load  = 1'b0;
        tmp1_load  = 1'b0;
        flags_load = 1'b0;
        mem_write  = 1'b0;
        alu_op     = alu_add;
        in_ready   = 1'b0;
        out_valid  = 1'b0;

        case (step)
            st_idle, st_halted: begin
                if (start) begin
                    step_nxt = st_fetch0;
                end
            end
            st_fetch0: begin
                bus_src  = src_pc;
                mar_load = 1'b1;
                step_nxt = st_fetch1;
            end
            st_fetch1: begin
                bus_src  = src_mem;
                ir_load  = 1'b1;
                pc_inc   = 1'b1;
                step_nxt = st_exec0;
            end
            default: begin  // execute steps
                step_nxt = st_fetch0;
                case (op)
                    op_sys: begin
                        case (sys)
                            sys_read: begin
                                bus_src  = src_in;
                                reg_addr = rx;
                                in_ready = 1'b1;
                                reg_load = in_valid;
                                if (!in_valid) begin
                                    step_nxt = st_exec0;  // wait for input
                                end
                            end
                            sys_write: begin
                                reg_addr  = rx;
                                out_valid = 1'b1;
                                if (!out_ready) begin
                                    step_nxt = st_exec0;  // back-pressure
                                end
                            end
                            default: begin  // halt
                                bus_src  = src_reg;  // r0 clears pc for next start
                                pc_load  = 1'b1;
                                step_nxt = st_halted;
                            end
                        endcase
                    end
                    op_setn: begin
                        bus_src  = src_imm;
                        reg_addr = rx;
                        reg_load = 1'b1;
                    end
                    op_jumpn: begin
                        bus_src = src_imm;
                        pc_load = 1'b1;
                    end
                    op_loadn, op_storen: begin
                        reg_addr = rx;
                        if (step == st_exec0) begin
                            bus_src  = src_imm;  // address into mar
                            mar_load = 1'b1;
                            step_nxt = st_exec1;
                        end else if (op == op_loadn) begin
                            bus_src  = src_mem;
                            reg_load = 1'b1;
                        end else begin
                            mem_write = 1'b1;
                        end
                    end
                    op_addn, op_add, op_sub, op_mul: begin
                        case (step)
                            st_exec0: begin
                                tmp0_load = 1'b1;
                                step_nxt  = st_exec1;
                                if (op == op_addn) begin
                                    bus_src = src_imm;
                                end else begin
                                    bus_src  = src_reg;
                                    reg_addr = (op == op_sub) ? ry : rz;
                                end
                            end
                            st_exec1: begin
                                bus_src   = src_reg;
                                tmp1_load = 1'b1;
                                step_nxt  = st_exec2;
                                if (op == op_addn) begin
                                    reg_addr = rx;
                                end else begin
                                    reg_addr = (op == op_sub) ? rz : ry;
                                end
                            end
                            default: begin  // result into x
                                bus_src  = src_alu;
                                reg_addr = rx;
                                reg_load = 1'b1;
                                if (op == op_sub) begin
                                    alu_op = alu_sub;
                                end else if (op == op_mul) begin
                                    alu_op = alu_mul;
                                end
                            end
                        endcase
                    end
                    op_jeqz, op_jnez, op_jltz, op_jgtz: begin
                        if (step == st_exec0) begin
                            bus_src    = src_reg;  // flags from x
                            reg_addr   = rx;
                            flags_load = 1'b1;
                            step_nxt   = st_exec1;
                        end else if (take) begin
                            bus_src = src_imm;
                            pc_load = 1'b1;
                        end
                    end
                    default: begin  // dropped opcodes stop the core
                        bus_src  = src_reg;
                        pc_load  = 1'b1;
                        step_nxt = st_halted;
                    end
                endcase
            end
        endcase
    end

    // a write holds its word until the consumer takes it
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(reg_addr));

    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        step == st_idle |-> !(reg_load || mar_load || ir_load || pc_inc || pc_load ||
                              tmp0_load || tmp1_load || flags_load || mem_write));

endmodule

//--- cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  logic           prog_valid,
    output logic           prog_ready,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    input  logic           in_valid,
    output logic           in_ready,
    input  cpu_pkg::word_t in_data,
    output logic           out_valid,
    input  logic           out_ready,
    output cpu_pkg::word_t out_data,
    output logic           halted
);
    import cpu_pkg::*;

    bus_src_t  bus_src;
    reg_addr_t reg_addr;
    alu_op_t   alu_op;
    word_t     ir;
    word_t     mem_rdata;
    word_t     mem_wdata;
    addr_t     mem_addr;
    logic      reg_load;
    logic      mar_load;
    logic      ir_load;
    logic      pc_inc;
    logic      pc_load;
    logic      tmp0_load;
    logic      tmp1_load;
    logic      flags_load;
    logic      mem_write;
    logic      zero_flag;
    logic      sign_flag;

    cpu_control ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .ir         (ir),
        .zero_flag  (zero_flag),
        .sign_flag  (sign_flag),
        .in_valid   (in_valid),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .prog_ready (prog_ready),
        .halted     (halted),
        .bus_src    (bus_src),
        .reg_addr   (reg_addr),
        .reg_load   (reg_load),
        .mar_load   (mar_load),
        .ir_load    (ir_load),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .tmp0_load  (tmp0_load),
        .tmp1_load  (tmp1_load),
        .flags_load (flags_load),
        .mem_write  (mem_write),
        .alu_op     (alu_op)
    );

    cpu_datapath dp0 (
        .clk        (clk),
        .rst        (rst),
        .bus_src    (bus_src),
        .reg_addr   (reg_addr),
        .reg_load   (reg_load),
        .mar_load   (mar_load),
        .ir_load    (ir_load),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .tmp0_load  (tmp0_load),
        .tmp1_load  (tmp1_load),
        .flags_load (flags_load),
        .alu_op     (alu_op),
        .mem_write  (mem_write),
        .ir         (ir),
        .zero_flag  (zero_flag),
        .sign_flag  (sign_flag),
        .in_data    (in_data),
        .mem_rdata  (mem_rdata),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .out_data   (out_data)
    );

    cpu_memory mem0 (
        .clk        (clk),
        .addr       (mem_addr),
        .wdata      (mem_wdata),
        .write      (mem_write),
        .rdata      (mem_rdata),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

endmodule

//--- tb_cpu_model.svh
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

typedef word_t word_q_t[$];

// instruction-level interpreter returning the words that write sends out
function automatic word_q_t run_model(input word_t image_in [256], input word_q_t inputs);
    word_t   mem [256];
    word_t   regs [16];
    word_q_t outs;
    addr_t   pc;
    word_t   w;
    word_t   vx;
    word_t   vy;
    word_t   vz;
    word_t   imm;
    int      in_pos;
    logic    jump;

    mem = image_in;
    foreach (regs[i]) regs[i] = '0;
    pc = '0;
    in_pos = 0;
    for (int n = 0; n < 100000; n++) begin
        w = mem[pc];
        pc = pc + 8'd1;
        vx = regs[w[11:8]];
        vy = regs[w[7:4]];
        vz = regs[w[3:0]];
        imm = {8'h00, w[7:0]};  // zero-extended
        jump = 1'b0;
        case (w[15:12])
            op_sys: begin
                if (w[1:0] == sys_read) begin
                    if (in_pos >= inputs.size()) return outs;
                    regs[w[11:8]] = inputs[in_pos];
                    in_pos++;
                end else if (w[1:0] == sys_write) begin
                    outs.push_back(vx);
                end else begin
                    return outs;  // halt and unused sub-function
                end
            end
            op_setn:   regs[w[11:8]] = imm;
            op_loadn:  regs[w[11:8]] = mem[w[7:0]];
            op_storen: mem[w[7:0]] = vx;
            op_addn:   regs[w[11:8]] = vx + imm;
            op_add:    regs[w[11:8]] = vy + vz;
            op_sub:    regs[w[11:8]] = vy - vz;
            op_mul:    regs[w[11:8]] = vy * vz;  // low 16 bits
            op_jumpn:  jump = 1'b1;
            op_jeqz:   jump = (vx == '0);
            op_jnez:   jump = (vx != '0);
            op_jltz:   jump = vx[15];
            op_jgtz:   jump = (vx != '0) && !vx[15];
            default:   return outs;  // dropped opcodes stop the core
        endcase
        if (jump) pc = w[7:0];
        regs[0] = '0;  // r0 stays zero
    end
    return outs;
endfunction

`endif

//--- tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;
    import cpu_pkg::*;

    `include "tb_cpu_model.svh"

    logic  clk;
    logic  rst;
    logic  start;
    logic  prog_valid;
    logic  prog_ready;
    addr_t prog_addr;
    word_t prog_data;
    logic  in_valid = 1'b0;
    logic  in_ready;
    word_t in_data = '0;
    logic  out_valid;
    logic  out_ready = 1'b0;
    word_t out_data;
    logic  halted;

    integer  seed = 32'ha72d;
    word_t   image [256];
    addr_t   wr_ptr;
    word_q_t prog_inputs;  // inputs of the program being built
    word_q_t in_list;      // every input handed to the DUT so far
    word_q_t exp_list;     // every expected output so far
    int      in_idx = 0;
    int      out_count = 0;
    logic    in_ready_q = 1'b0;

    cpu_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .prog_valid (prog_valid),
        .prog_ready (prog_ready),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // input gaps, output back-pressure and the output compare on the falling edge
    always @(negedge clk) begin : drive_and_compare
        int rnd;
        if (rst) begin
            in_valid = 1'b0;
            out_ready = 1'b0;
            in_ready_q = 1'b0;
        end else begin
            if (in_valid && in_ready_q) begin  // taken at the last rising edge
                in_valid = 1'b0;
                in_idx++;
            end
            rnd = $random(seed);
            if (!in_valid && in_idx < in_list.size() && (rnd & 3) == 0) begin
                in_valid = 1'b1;
                in_data = in_list[in_idx];
            end
            in_ready_q = in_ready;
            rnd = $random(seed);
            out_ready = rnd[4];
            if (out_valid && out_ready) begin  // word leaves on the next rising edge
                if (out_count >= exp_list.size()) begin
                    report_problem("output word appeared with none expected");
                end
                check_word("out_data", out_data, exp_list[out_count]);
                out_count++;
            end
        end
    end

    function automatic word_t three_reg(input op_t op, input int x, input int y, input int z);
        return {op, x[3:0], y[3:0], z[3:0]};
    endfunction

    function automatic word_t reg_imm(input op_t op, input int x, input int imm);
        return {op, x[3:0], imm[7:0]};
    endfunction

    function automatic word_t sys_op(input sys_t s, input int x);
        return {op_sys, x[3:0], 6'b0, s};
    endfunction

    task automatic clear_image();
        int a;
        for (a = 0; a < 256; a++) begin
            image[a] = {a[7:0] ^ 8'h5a, a[7:0]};
        end
        wr_ptr = '0;
    endtask

    task automatic emit(input word_t w);
        image[wr_ptr] = w;
        wr_ptr++;
    endtask

    // marker write is skipped when the branch is taken
    task automatic cond_jump(input op_t op, input int x, input int marker);
        emit(reg_imm(op, x, int'(wr_ptr) + 3));
        emit(reg_imm(op_setn, 14, marker));
        emit(sys_op(sys_write, 14));
    endtask

    task automatic load_image();
        int a;
        int n;
        for (a = 0; a < 256; a++) begin
            @(negedge clk);
            prog_valid = 1'b1;
            prog_addr = addr_t'(a);
            prog_data = image[a];
            n = 0;
            while (!prog_ready) begin
                @(negedge clk);
                n++;
                if (n > 100) report_problem("prog_ready stayed low during program load");
            end
        end
        @(negedge clk);
        prog_valid = 1'b0;
    endtask

    task automatic wait_for_halt(input int limit);
        int n;
        n = 0;
        while (!halted) begin
            @(negedge clk);
            n++;
            if (n > limit) report_problem("core did not halt in time");
        end
    endtask

    task automatic run_program(input string name);
        word_q_t expected;
        expected = run_model(image, prog_inputs);
        foreach (expected[i]) exp_list.push_back(expected[i]);
        foreach (prog_inputs[i]) in_list.push_back(prog_inputs[i]);
        prog_inputs.delete();
        load_image();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_flag("halted", halted, 1'b0);
        wait_for_halt(20000);
        repeat (20) @(negedge clk);  // watch for stray outputs
        check_flag("halted", halted, 1'b1);
        check_flag("prog_ready", prog_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);
        if (out_count != exp_list.size()) begin
            report_problem($sformatf("%s: %0d of %0d outputs seen", name, out_count,
                                     exp_list.size()));
        end
        if (in_idx != in_list.size()) begin
            report_problem($sformatf("%s: %0d of %0d inputs consumed", name, in_idx,
                                     in_list.size()));
        end
        $display("%s done, %0d words out", name, expected.size());
    endtask

    initial begin : main
        int loop;
        rst = 1'b1;
        start = 1'b0;
        prog_valid = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check_flag("prog_ready", prog_ready, 1'b1);
        check_flag("halted", halted, 1'b0);

        clear_image();  // arithmetic and memory
        emit(reg_imm(op_setn, 1, 200));
        emit(reg_imm(op_setn, 2, 100));
        emit(reg_imm(op_addn, 1, 250));
        emit(sys_op(sys_write, 1));
        emit(three_reg(op_add, 3, 1, 2));
        emit(sys_op(sys_write, 3));
        emit(three_reg(op_add, 4, 0, 3));  // copy
        emit(sys_op(sys_write, 4));
        emit(three_reg(op_sub, 5, 2, 1));  // wraps below zero
        emit(sys_op(sys_write, 5));
        emit(three_reg(op_sub, 6, 0, 2));  // neg
        emit(sys_op(sys_write, 6));
        emit(reg_imm(op_setn, 7, 255));
        emit(three_reg(op_mul, 8, 7, 7));
        emit(sys_op(sys_write, 8));
        emit(three_reg(op_mul, 9, 8, 8));
        emit(sys_op(sys_write, 9));
        emit(three_reg(op_add, 10, 5, 8));
        emit(sys_op(sys_write, 10));
        emit(reg_imm(op_storen, 1, 8'h80));
        emit(reg_imm(op_storen, 5, 8'h81));
        emit(reg_imm(op_storen, 9, 8'hc3));
        emit(reg_imm(op_loadn, 11, 8'h81));
        emit(sys_op(sys_write, 11));
        emit(reg_imm(op_loadn, 12, 8'h80));
        emit(sys_op(sys_write, 12));
        emit(reg_imm(op_loadn, 13, 8'hc3));
        emit(sys_op(sys_write, 13));
        emit(reg_imm(op_loadn, 11, 8'h90));  // fill word
        emit(sys_op(sys_write, 11));
        emit(three_reg(op_add, 0, 0, 0));  // nop
        emit(sys_op(sys_halt, 0));
        run_program("arithmetic");

        clear_image();  // input loop and branches
        emit(reg_imm(op_setn, 1, 3));
        emit(reg_imm(op_setn, 15, 1));
        loop = int'(wr_ptr);
        emit(sys_op(sys_read, 2));
        emit(reg_imm(op_addn, 2, 7));
        emit(sys_op(sys_write, 2));
        emit(three_reg(op_sub, 1, 1, 15));
        emit(reg_imm(op_jnez, 1, loop));
        emit(reg_imm(op_jumpn, 0, int'(wr_ptr) + 2));
        emit(sys_op(sys_halt, 0));  // jumped over
        emit(reg_imm(op_setn, 5, 5));
        emit(three_reg(op_sub, 6, 0, 5));
        cond_jump(op_jeqz, 0, 1);
        cond_jump(op_jeqz, 5, 2);
        cond_jump(op_jnez, 0, 3);
        cond_jump(op_jltz, 6, 4);
        cond_jump(op_jltz, 5, 5);
        cond_jump(op_jltz, 0, 6);
        cond_jump(op_jgtz, 5, 7);
        cond_jump(op_jgtz, 0, 8);
        cond_jump(op_jgtz, 6, 9);
        emit(sys_op(sys_halt, 0));
        prog_inputs.push_back(16'hfffc);
        prog_inputs.push_back(16'h1234);
        prog_inputs.push_back(16'h8000);
        run_program("input and branches");

        clear_image();  // register-indirect group is gone
        emit(reg_imm(op_setn, 1, 8'h42));
        emit(sys_op(sys_write, 1));
        emit(16'h4100);
        emit(sys_op(sys_write, 1));
        emit(sys_op(sys_halt, 0));
        run_program("dropped 0100");

        clear_image();  // div encoding
        emit(reg_imm(op_setn, 2, 9));
        emit(sys_op(sys_write, 2));
        emit(16'h9123);
        emit(sys_op(sys_write, 2));
        emit(sys_op(sys_halt, 0));
        run_program("dropped div");

        clear_image();  // unused system sub-function
        emit(reg_imm(op_setn, 3, 8'h77));
        emit(sys_op(sys_write, 3));
        emit({op_sys, 4'h3, 8'h03});
        emit(sys_op(sys_write, 3));
        emit(sys_op(sys_halt, 0));
        run_program("dropped sys");

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
cpu_pkg.sv
cpu_regfile.sv
cpu_alu.sv
cpu_memory.sv
cpu_datapath.sv
cpu_control.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       ?= tb_cpu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_TEXT ?= PASS: all tests

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
